// ==== common/board_consts.svh ====
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

`default_nettype none

// ****************************************
// Board widths
// ****************************************

// Switch and LED pins on the board header
`define GPIO_WIDTH 17

// Host register bus
`define HOST_DW 32
`define HOST_AW 4

// Fan PWM counter, one period is 2**PWM_CW cycles
`define PWM_CW 8

// ****************************************
// Reset values
// ****************************************

// Duty of a full period keeps the fan always on
`define FAN_DUTY_RST 256

// All pins start as inputs (tristate)
`define GPIO_DIR_RST {`GPIO_WIDTH{1'b1}}

`default_nettype wire

`endif

// ==== common/board_pkg.sv ====
`include "board_consts.svh"

`default_nettype none

package board_pkg;

  // ****************************************
  // Host register map
  // ****************************************

  // Word addresses seen by the host
  typedef enum logic [`HOST_AW-1:0] {
    // Pin output values
    REG_GPIO_OUT   = 4'd0,
    // Pin direction, a set bit tristates the pin
    REG_GPIO_DIR   = 4'd1,
    // Synchronized pin levels, read only
    REG_GPIO_IN    = 4'd2,
    // Sticky rising-edge flags, write one to clear
    REG_IRQ_STATUS = 4'd3,
    // Interrupt enable per pin
    REG_IRQ_MASK   = 4'd4,
    // Fan duty in counter ticks per period
    REG_FAN_DUTY   = 4'd5
  } reg_addr_e;

  // ****************************************
  // Fan PWM output phase
  // ****************************************

  // HIGH and LOW split each period
  // FULL holds the output high with no low part
  typedef enum logic [1:0] {
    PWM_HIGH = 2'd0,
    PWM_LOW  = 2'd1,
    PWM_FULL = 2'd2
  } pwm_phase_e;

endpackage

`default_nettype wire

// ==== verilog/host_reg_decode.sv ====
`timescale 1ns/1ns

`include "board_consts.svh"

`default_nettype none

module host_reg_decode (
  input  logic                  sys_clk_i,
  input  logic                  rst_n_i,

  // Host strobes, never both high
  input  logic                  host_wr_i,
  input  logic                  host_rd_i,
  input  board_pkg::reg_addr_e  host_addr_i,

  // Per-block write enables
  output logic                  gpio_wr_o,
  output logic                  fan_wr_o,

  // Combinational read data from the blocks
  input  logic [`HOST_DW-1:0]   gpio_rdata_i,
  input  logic [`HOST_DW-1:0]   fan_rdata_i,

  // Registered read return
  output logic [`HOST_DW-1:0]   host_rdata_o,
  output logic                  host_rvalid_o
);

  import board_pkg::*;

  logic                 gpio_sel;
  logic                 fan_sel;
  logic [`HOST_DW-1:0]  rd_mux;

  // ****************************************
  // Address decode
  // ****************************************

  // GPIO owns the pin and interrupt registers
  always_comb begin
    gpio_sel = 1'b0;
    fan_sel  = 1'b0;
    case (host_addr_i)
      REG_GPIO_OUT,
      REG_GPIO_DIR,
      REG_GPIO_IN,
      REG_IRQ_STATUS,
      REG_IRQ_MASK:   gpio_sel = 1'b1;
      REG_FAN_DUTY:   fan_sel  = 1'b1;
      default: begin
        gpio_sel = 1'b0;
        fan_sel  = 1'b0;
      end
    endcase
  end

  // Input register is read only, so no write enable for it
  assign gpio_wr_o = host_wr_i & gpio_sel & (host_addr_i != REG_GPIO_IN);
  assign fan_wr_o  = host_wr_i & fan_sel;

  // Unmapped addresses read as zero
  assign rd_mux = gpio_sel ? gpio_rdata_i :
                  fan_sel  ? fan_rdata_i  : '0;

  // ****************************************
  // Read return
  // ****************************************

  // Valid pulses one cycle after the strobe
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      host_rvalid_o <= 1'b0;
    end else begin
      host_rvalid_o <= host_rd_i;
    end
  end

  // Data held until the next read
  always_ff @(posedge sys_clk_i) begin
    if (host_rd_i) begin
      host_rdata_o <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== gpio/gpio_bank.sv ====
`timescale 1ns/1ns

`include "board_consts.svh"

`default_nettype none

module gpio_bank (
  input  logic                    sys_clk_i,
  input  logic                    rst_n_i,

  // Register access from the decoder
  input  logic                    wr_i,
  input  board_pkg::reg_addr_e    addr_i,
  input  logic [`HOST_DW-1:0]     wdata_i,
  output logic [`HOST_DW-1:0]     rdata_o,

  // Board pins
  input  logic [`GPIO_WIDTH-1:0]  gpio_i_i,
  output logic [`GPIO_WIDTH-1:0]  gpio_o_o,
  output logic [`GPIO_WIDTH-1:0]  gpio_t_o,

  // Level interrupt to the host
  output logic                    irq_o
);

  import board_pkg::*;

  // Software registers
  logic [`GPIO_WIDTH-1:0] out_q;
  logic [`GPIO_WIDTH-1:0] dir_q;
  logic [`GPIO_WIDTH-1:0] mask_q;
  logic [`GPIO_WIDTH-1:0] status_q;

  // Input synchronizer and edge history
  logic [`GPIO_WIDTH-1:0] in_meta_q;
  logic [`GPIO_WIDTH-1:0] in_sync_q;
  logic [`GPIO_WIDTH-1:0] in_prev_q;

  logic [`GPIO_WIDTH-1:0] wdata_pins;
  logic [`GPIO_WIDTH-1:0] rise;
  logic [`GPIO_WIDTH-1:0] w1c;

  // Only the low bits map onto pins
  assign wdata_pins = wdata_i[`GPIO_WIDTH-1:0];

  // ****************************************
  // Output and direction
  // ****************************************

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      out_q  <= '0;
      dir_q  <= `GPIO_DIR_RST;
      mask_q <= '0;
    end else if (wr_i) begin
      case (addr_i)
        REG_GPIO_OUT: out_q  <= wdata_pins;
        REG_GPIO_DIR: dir_q  <= wdata_pins;
        REG_IRQ_MASK: mask_q <= wdata_pins;
        default:      out_q  <= out_q;
      endcase
    end
  end

  // Set direction bit means the pad is tristated
  assign gpio_o_o = out_q;
  assign gpio_t_o = dir_q;

  // ****************************************
  // Input path
  // ****************************************

  // Two flops for metastability and a third for edge history
  always_ff @(posedge sys_clk_i) begin
    in_meta_q <= gpio_i_i;
    in_sync_q <= in_meta_q;
    in_prev_q <= in_sync_q;
  end

  assign rise = in_sync_q & ~in_prev_q;

  // ****************************************
  // Interrupt status
  // ****************************************

  // Write one to clear
  assign w1c = (wr_i && (addr_i == REG_IRQ_STATUS)) ? wdata_pins : '0;

  // A new edge wins over a clear in the same cycle
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~w1c) | rise;
    end
  end

  assign irq_o = |(status_q & mask_q);

  // ****************************************
  // Read mux
  // ****************************************

  always_comb begin
    rdata_o = '0;
    case (addr_i)
      REG_GPIO_OUT:   rdata_o[`GPIO_WIDTH-1:0] = out_q;
      REG_GPIO_DIR:   rdata_o[`GPIO_WIDTH-1:0] = dir_q;
      REG_GPIO_IN:    rdata_o[`GPIO_WIDTH-1:0] = in_sync_q;
      REG_IRQ_STATUS: rdata_o[`GPIO_WIDTH-1:0] = status_q;
      REG_IRQ_MASK:   rdata_o[`GPIO_WIDTH-1:0] = mask_q;
      default:        rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== fan/fan_pwm.sv ====
`timescale 1ns/1ns

`include "board_consts.svh"

`default_nettype none

module fan_pwm (
  input  logic                sys_clk_i,
  input  logic                rst_n_i,

  // Duty register access
  input  logic                wr_i,
  input  logic [`HOST_DW-1:0] wdata_i,
  output logic [`HOST_DW-1:0] rdata_o,

  // Fan drive pin
  output logic                fan_pwm_o
);

  import board_pkg::*;

  // One extra bit so a full period fits
  logic [`PWM_CW:0]   duty_q;
  logic [`PWM_CW:0]   shadow_q;
  logic [`PWM_CW:0]   shadow_d;

  logic [`PWM_CW-1:0] cnt_q;
  logic [`PWM_CW-1:0] cnt_d;
  logic               wrap;

  pwm_phase_e         phase_q;
  pwm_phase_e         phase_d;

  // ****************************************
  // Duty register
  // ****************************************

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      duty_q <= (`PWM_CW+1)'(`FAN_DUTY_RST);
    end else if (wr_i) begin
      duty_q <= wdata_i[`PWM_CW:0];
    end
  end

  assign rdata_o = {{(`HOST_DW-`PWM_CW-1){1'b0}}, duty_q};

  // ****************************************
  // Counter and shadow duty
  // ****************************************

  // Last count of the period
  assign wrap  = (cnt_q == {`PWM_CW{1'b1}});
  assign cnt_d = cnt_q + 1'b1;

  // New duty is picked up only on the wrap
  assign shadow_d = wrap ? duty_q : shadow_q;

  // Phase for the count that comes next
  always_comb begin
    if (shadow_d[`PWM_CW]) begin
      phase_d = PWM_FULL;
    end else if ({1'b0, cnt_d} < shadow_d) begin
      phase_d = PWM_HIGH;
    end else begin
      phase_d = PWM_LOW;
    end
  end

  // Reset starts fully on like the tied pin
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      shadow_q <= (`PWM_CW+1)'(`FAN_DUTY_RST);
      phase_q  <= PWM_FULL;
    end else begin
      cnt_q    <= cnt_d;
      shadow_q <= shadow_d;
      phase_q  <= phase_d;
    end
  end

  // High in both HIGH and FULL
  assign fan_pwm_o = (phase_q != PWM_LOW);

endmodule

`default_nettype wire

// ==== verilog/board_top.sv ====
`timescale 1ns/1ns

`include "board_consts.svh"

`default_nettype none

module board_top (
  input  logic                    sys_clk_i,
  input  logic                    rst_n_i,

  // Host register bus
  input  logic                    host_wr_i,
  input  logic                    host_rd_i,
  input  board_pkg::reg_addr_e    host_addr_i,
  input  logic [`HOST_DW-1:0]     host_wdata_i,
  output logic [`HOST_DW-1:0]     host_rdata_o,
  output logic                    host_rvalid_o,

  // Board pins, split in place of an IO buffer
  input  logic [`GPIO_WIDTH-1:0]  gpio_i_i,
  output logic [`GPIO_WIDTH-1:0]  gpio_o_o,
  output logic [`GPIO_WIDTH-1:0]  gpio_t_o,

  output logic                    irq_o,
  output logic                    fan_pwm_o
);

  // Block enables and read data
  logic                 gpio_wr;
  logic                 fan_wr;
  logic [`HOST_DW-1:0]  gpio_rdata;
  logic [`HOST_DW-1:0]  fan_rdata;

  // ****************************************
  // Register decoder
  // ****************************************

  host_reg_decode i_host_reg_decode (
    .sys_clk_i     (sys_clk_i),
    .rst_n_i       (rst_n_i),
    .host_wr_i     (host_wr_i),
    .host_rd_i     (host_rd_i),
    .host_addr_i   (host_addr_i),
    .gpio_wr_o     (gpio_wr),
    .fan_wr_o      (fan_wr),
    .gpio_rdata_i  (gpio_rdata),
    .fan_rdata_i   (fan_rdata),
    .host_rdata_o  (host_rdata_o),
    .host_rvalid_o (host_rvalid_o));

  // ****************************************
  // Peripherals
  // ****************************************

  // Address and data go straight to the blocks
  gpio_bank i_gpio_bank (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .wr_i      (gpio_wr),
    .addr_i    (host_addr_i),
    .wdata_i   (host_wdata_i),
    .rdata_o   (gpio_rdata),
    .gpio_i_i  (gpio_i_i),
    .gpio_o_o  (gpio_o_o),
    .gpio_t_o  (gpio_t_o),
    .irq_o     (irq_o));

  fan_pwm i_fan_pwm (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .wr_i      (fan_wr),
    .wdata_i   (host_wdata_i),
    .rdata_o   (fan_rdata),
    .fan_pwm_o (fan_pwm_o));

endmodule

`default_nettype wire

// ==== verification/board_props.sv ====
`timescale 1ns/1ns

`default_nettype none

module board_props (
  input logic sys_clk_i,
  input logic rst_n_i,
  input logic host_wr_i,
  input logic host_rd_i,
  input logic host_rvalid_i,
  input logic irq_i
);

  // ****************************************
  // Host bus
  // ****************************************

  // Valid exactly one cycle after a read strobe
  rvalid_after_read: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i) host_rd_i |=> host_rvalid_i)
    else $error("host_rvalid_o missing one cycle after a read strobe");

  // And never without one
  rvalid_only_after_read: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i) !host_rd_i |=> !host_rvalid_i)
    else $error("host_rvalid_o high without a read strobe the cycle before");

  strobes_exclusive: assert property (
    @(posedge sys_clk_i) disable iff (!rst_n_i) !(host_wr_i && host_rd_i))
    else $error("host read and write strobes high together");

  // Interrupt quiet once reset has been seen for a cycle
  irq_low_in_reset: assert property (
    @(posedge sys_clk_i) (!rst_n_i && $past(!rst_n_i)) |-> !irq_i)
    else $error("irq_o high during reset");

endmodule

// Host bus and interrupt ports of the board top
bind board_top board_props u_board_props (
  .sys_clk_i     (sys_clk_i),
  .rst_n_i       (rst_n_i),
  .host_wr_i     (host_wr_i),
  .host_rd_i     (host_rd_i),
  .host_rvalid_i (host_rvalid_o),
  .irq_i         (irq_o));

`default_nettype wire

// ==== verification/board_tb.sv ====
`timescale 1ns/1ns

`include "board_consts.svh"

`default_nettype none

module board_tb;

  import board_pkg::*;

  localparam int RST_CYCLES = 10;
  localparam int PWM_PERIOD = 1 << `PWM_CW;
  localparam int PIN_HOLD   = 4;
  localparam int RD_TIMEOUT = 8;
  localparam int N_RB       = 40;
  localparam int N_IN       = 20;
  localparam int N_IRQ      = 20;
  localparam int N_FAN      = 4;
  // Rough cycle budget of every test section, fan periods dominate
  localparam int TEST_CYCLES = RST_CYCLES + 20 + N_RB * 10 + N_IN * 10 + N_IRQ * 20
                               + N_FAN * (3 * PWM_PERIOD + 10);
  localparam int MARGIN     = 1000;

  logic                   sys_clk;
  logic                   rst_n;
  logic                   host_wr;
  logic                   host_rd;
  reg_addr_e              host_addr;
  logic [`HOST_DW-1:0]    host_wdata;
  logic [`HOST_DW-1:0]    host_rdata;
  logic                   host_rvalid;
  logic [`GPIO_WIDTH-1:0] gpio_in;
  logic [`GPIO_WIDTH-1:0] gpio_out;
  logic [`GPIO_WIDTH-1:0] gpio_tri;
  logic                   irq;
  logic                   fan_pwm;

  // Model of the register state
  logic [`GPIO_WIDTH-1:0] exp_out;
  logic [`GPIO_WIDTH-1:0] exp_dir;
  logic [`GPIO_WIDTH-1:0] exp_mask;
  logic [`GPIO_WIDTH-1:0] exp_status;
  logic [`GPIO_WIDTH-1:0] pins_q;
  logic [`HOST_DW-1:0]    exp_duty;

  logic [31:0]            lfsr_q;
  int                     word_errs;
  int                     pin_errs;
  int                     level_errs;
  int                     proto_errs;

  board_top DUT (
    .sys_clk_i     (sys_clk),
    .rst_n_i       (rst_n),
    .host_wr_i     (host_wr),
    .host_rd_i     (host_rd),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_rdata_o  (host_rdata),
    .host_rvalid_o (host_rvalid),
    .gpio_i_i      (gpio_in),
    .gpio_o_o      (gpio_out),
    .gpio_t_o      (gpio_tri),
    .irq_o         (irq),
    .fan_pwm_o     (fan_pwm));

  // 4 ns clock
  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  // ****************************************
  // Random source and word helpers
  // ****************************************

  // Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Pin registers read back in the low bits
  function automatic logic [`HOST_DW-1:0] pin_word(input logic [`HOST_DW-1:0] d);
    return {{(`HOST_DW-`GPIO_WIDTH){1'b0}}, d[`GPIO_WIDTH-1:0]};
  endfunction

  // Duty holds one bit more than the counter
  function automatic logic [`HOST_DW-1:0] duty_word(input logic [`HOST_DW-1:0] d);
    return {{(`HOST_DW-`PWM_CW-1){1'b0}}, d[`PWM_CW:0]};
  endfunction

  // ****************************************
  // Compare tasks
  // ****************************************

  task automatic check_word(input string name, input logic [`HOST_DW-1:0] got,
                            input logic [`HOST_DW-1:0] exp);
    if (got !== exp) begin
      word_errs++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_pins(input string name, input logic [`GPIO_WIDTH-1:0] got,
                            input logic [`GPIO_WIDTH-1:0] exp);
    if (got !== exp) begin
      pin_errs++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      level_errs++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // ****************************************
  // Host bus and pin drivers
  // ****************************************

  // Called on a falling edge, returns on the next one
  task automatic host_write(input reg_addr_e addr, input logic [`HOST_DW-1:0] data);
    host_wr    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(negedge sys_clk);
    host_wr = 1'b0;
  endtask

  // Waits for the valid flag, which should come after one cycle
  task automatic host_read(input reg_addr_e addr, output logic [`HOST_DW-1:0] data);
    int waited;
    host_rd   = 1'b1;
    host_addr = addr;
    @(negedge sys_clk);
    host_rd = 1'b0;
    waited  = 1;
    while (!host_rvalid && waited < RD_TIMEOUT) begin
      @(negedge sys_clk);
      waited++;
    end
    data = host_rdata;
    if (!host_rvalid) begin
      proto_errs++;
      $display("Read at address 0x%0h never got a valid flag", addr);
    end else if (waited != 1) begin
      proto_errs++;
      $display("Read at address 0x%0h got its valid flag after %0d cycles", addr, waited);
    end
  endtask

  task automatic check_reg(input reg_addr_e addr, input logic [`HOST_DW-1:0] exp);
    logic [`HOST_DW-1:0] got;
    host_read(addr, got);
    check_word($sformatf("host_rdata_o at 0x%0h", addr), got, exp);
  endtask

  // Rising edges go sticky in the model right away
  task automatic set_pins(input logic [`GPIO_WIDTH-1:0] val);
    gpio_in    = val;
    exp_status = exp_status | (val & ~pins_q);
    pins_q     = val;
    // Two sync flops and the edge flop, plus a spare cycle
    repeat (PIN_HOLD) @(negedge sys_clk);
  endtask

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    logic [`HOST_DW-1:0] wd;
    logic [31:0]         sel;
    reg_addr_e           addr;
    int                  duty;
    int                  high_cnt;
    lfsr_q     = 32'h79a3;
    rst_n      = 1'b0;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = REG_GPIO_OUT;
    host_wdata = '0;
    gpio_in    = '0;
    pins_q     = '0;
    exp_out    = '0;
    exp_dir    = {`GPIO_WIDTH{1'b1}};
    exp_mask   = '0;
    exp_status = '0;
    // Full period duty, fan on
    exp_duty   = 32'd256;
    word_errs  = 0;
    pin_errs   = 0;
    level_errs = 0;
    proto_errs = 0;
    repeat (RST_CYCLES) @(negedge sys_clk);
    rst_n = 1'b1;
    @(negedge sys_clk);

    // Reset values on the pins and in the registers
    check_level("host_rvalid_o", host_rvalid, 1'b0);
    check_level("irq_o", irq, 1'b0);
    check_level("fan_pwm_o", fan_pwm, 1'b1);
    check_pins("gpio_o_o", gpio_out, exp_out);
    check_pins("gpio_t_o", gpio_tri, exp_dir);
    check_reg(REG_GPIO_OUT, pin_word(exp_out));
    check_reg(REG_GPIO_DIR, pin_word(exp_dir));
    check_reg(REG_GPIO_IN, '0);
    check_reg(REG_IRQ_STATUS, '0);
    check_reg(REG_IRQ_MASK, '0);
    check_reg(REG_FAN_DUTY, exp_duty);

    // Readback of writable registers, plus one unmapped read each time
    for (int i = 0; i < N_RB; i++) begin
      wd  = rand_bits(32);
      sel = rand_bits(2);
      case (sel)
        0: begin
          addr    = REG_GPIO_OUT;
          exp_out = wd[`GPIO_WIDTH-1:0];
        end
        1: begin
          addr    = REG_GPIO_DIR;
          exp_dir = wd[`GPIO_WIDTH-1:0];
        end
        2: begin
          addr     = REG_IRQ_MASK;
          exp_mask = wd[`GPIO_WIDTH-1:0];
        end
        default: begin
          addr     = REG_FAN_DUTY;
          exp_duty = duty_word(wd);
        end
      endcase
      host_write(addr, wd);
      check_pins("gpio_o_o", gpio_out, exp_out);
      check_pins("gpio_t_o", gpio_tri, exp_dir);
      check_reg(addr, (addr == REG_FAN_DUTY) ? exp_duty : pin_word(wd));
      sel = rand_bits(3) + 32'd6;
      check_reg(reg_addr_e'(sel[`HOST_AW-1:0]), '0);
    end

    // Input path through the synchronizer
    for (int i = 0; i < N_IN; i++) begin
      wd = rand_bits(`GPIO_WIDTH);
      set_pins(wd[`GPIO_WIDTH-1:0]);
      check_reg(REG_GPIO_IN, pin_word(pins_q));
      check_level("irq_o", irq, |(exp_status & exp_mask));
    end

    // Edge capture, masking and write-one-to-clear
    for (int i = 0; i < N_IRQ; i++) begin
      wd = rand_bits(`GPIO_WIDTH);
      host_write(REG_IRQ_MASK, wd);
      exp_mask = wd[`GPIO_WIDTH-1:0];
      wd = rand_bits(`GPIO_WIDTH);
      set_pins(wd[`GPIO_WIDTH-1:0]);
      check_reg(REG_IRQ_STATUS, pin_word(exp_status));
      check_level("irq_o", irq, |(exp_status & exp_mask));
      wd = rand_bits(`GPIO_WIDTH);
      host_write(REG_IRQ_STATUS, wd);
      exp_status = exp_status & ~wd[`GPIO_WIDTH-1:0];
      check_reg(REG_IRQ_STATUS, pin_word(exp_status));
      check_level("irq_o", irq, |(exp_status & exp_mask));
    end

    // Fan duty, last pass is full on
    for (int i = 0; i < N_FAN; i++) begin
      if (i == N_FAN - 1) begin
        duty = PWM_PERIOD;
      end else begin
        duty = int'(rand_bits(`PWM_CW));
      end
      host_write(REG_FAN_DUTY, `HOST_DW'(duty));
      check_reg(REG_FAN_DUTY, `HOST_DW'(duty));
      // New duty loads on a wrap, two periods leave it settled
      repeat (2 * PWM_PERIOD) @(negedge sys_clk);
      high_cnt = 0;
      repeat (PWM_PERIOD) begin
        @(negedge sys_clk);
        if (fan_pwm) begin
          high_cnt++;
        end
      end
      check_word("fan_pwm_o high cycles", `HOST_DW'(high_cnt), `HOST_DW'(duty));
    end

    $display("Error counts: data %0d, pins %0d, levels %0d, protocol %0d",
             word_errs, pin_errs, level_errs, proto_errs);
    if (word_errs + pin_errs + level_errs + proto_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TEST_CYCLES + MARGIN) @(posedge sys_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish",
             TEST_CYCLES + MARGIN);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/board_pkg.sv
verilog/host_reg_decode.sv
gpio/gpio_bank.sv
fan/fan_pwm.sv
verilog/board_top.sv
verification/board_props.sv
verification/board_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the board testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module board_tb --Mdir "$BUILD_DIR" -o board_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/board_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^CHECKS FAILED$" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0
